// File: l1_cache.f
design/l1_cache_pkg.sv
design/l1_req_fifo.sv
design/l1_tag_data_ram.sv
design/l1_ctrl.sv
design/l1_cache_top.sv
test/bus_mem_model.sv
test/tb_l1_cache.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 -f l1_cache.f \
		--top-module tb_l1_cache -o sim_l1_cache
	./obj_dir/sim_l1_cache | tee /dev/stderr | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

// File: test/tb_l1_cache.sv
`timescale 1ns/1ps

module tb_l1_cache
    import l1_cache_pkg::*;
();

    localparam logic [DATA_W-1:0] MEM_KEY = 32'hc3a5_1e0f;
    localparam int N_ENTRIES = 19;
    localparam int TIMEOUT   = 300;
    localparam int STALL_MIN = 8;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              miss;
        logic              stall;
    } entry_t;

    // Set 3 holds blocks 0x1000, 0x2000 and 0x3000 in turn
    entry_t stim [N_ENTRIES] = '{
        '{32'h0000_1030, 1'b1, 1'b0},
        '{32'h0000_1034, 1'b0, 1'b0},
        '{32'h0000_103c, 1'b0, 1'b0},
        '{32'h0000_2038, 1'b1, 1'b0},
        '{32'h0000_1030, 1'b0, 1'b0},
        '{32'h0000_2030, 1'b0, 1'b0},
        '{32'h0000_3030, 1'b1, 1'b0},
        '{32'h0000_2034, 1'b0, 1'b0},
        '{32'h0000_1038, 1'b1, 1'b0},
        '{32'h0000_3034, 1'b0, 1'b0},
        '{32'h0000_2030, 1'b1, 1'b0},
        '{32'h0000_0480, 1'b1, 1'b1},
        '{32'h0000_0484, 1'b0, 1'b0},
        '{32'h0000_1038, 1'b0, 1'b0},
        '{32'h0000_2030, 1'b0, 1'b0},
        '{32'h0000_048c, 1'b0, 1'b1},
        '{32'h0000_3030, 1'b1, 1'b0},
        '{32'h0000_1030, 1'b1, 1'b0},
        '{32'habcd_0f04, 1'b1, 1'b0}
    };

    logic               clk = 1'b0;
    logic               rstn;
    logic               req_valid;
    logic [ADDR_W-1:0]  req_addr;
    logic               req_ready;
    logic               rsp_valid;
    logic [DATA_W-1:0]  rsp_data;
    logic               rsp_ready;
    logic               bus_req_valid;
    logic [ADDR_W-1:0]  bus_req_addr;
    logic               bus_req_ready;
    logic               bus_rsp_valid;
    logic [BLOCK_W-1:0] bus_rsp_block;
    logic               bus_rsp_ready;
    logic [ADDR_W-1:0]  bus_last_addr;
    int                 bus_count;
    int                 pushed = 0;

    always #10 clk = ~clk;

    l1_cache_top #(
        .ADDR_W     (ADDR_W),
        .DATA_W     (DATA_W),
        .BLOCK_W    (BLOCK_W),
        .WAYS       (WAYS),
        .SETS       (SETS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_l1_cache_top (
        .clk_i           (clk),
        .rstn_i          (rstn),
        .req_valid_i     (req_valid),
        .req_addr_i      (req_addr),
        .req_ready_o     (req_ready),
        .rsp_valid_o     (rsp_valid),
        .rsp_data_o      (rsp_data),
        .rsp_ready_i     (rsp_ready),
        .bus_req_valid_o (bus_req_valid),
        .bus_req_addr_o  (bus_req_addr),
        .bus_req_ready_i (bus_req_ready),
        .bus_rsp_valid_i (bus_rsp_valid),
        .bus_rsp_block_i (bus_rsp_block),
        .bus_rsp_ready_o (bus_rsp_ready)
    );

    bus_mem_model #(
        .ADDR_W  (ADDR_W),
        .DATA_W  (DATA_W),
        .BLOCK_W (BLOCK_W),
        .MEM_KEY (MEM_KEY)
    ) u_bus_mem_model (
        .clk_i       (clk),
        .rstn_i      (rstn),
        .req_valid_i (bus_req_valid),
        .req_addr_i  (bus_req_addr),
        .req_ready_o (bus_req_ready),
        .rsp_valid_o (bus_rsp_valid),
        .rsp_block_o (bus_rsp_block),
        .rsp_ready_i (bus_rsp_ready),
        .last_addr_o (bus_last_addr),
        .req_count_o (bus_count)
    );

    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: the cache stopped responding while %s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "Stopped on timeout");
    endtask

    task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                              input string what);
        if (got !== exp) begin
            report_error($sformatf("%s: got %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_miss(input bit got, input bit exp, input string what);
        if (got != exp) begin
            report_error($sformatf("%s: got miss=%0b, expected miss=%0b", what, got, exp));
        end
    endtask

    task automatic check_bus_addr(input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] exp,
                                  input string what);
        if (got !== exp) begin
            report_error($sformatf("%s: got %h, expected %h", what, got, exp));
        end
    endtask

    // Pushes every table entry as fast as req_ready allows
    task automatic drive_requests();
        int wait_cnt;
        @(posedge clk);
        for (int i = 0; i < N_ENTRIES; i++) begin
            req_valid <= 1'b1;
            req_addr  <= stim[i].addr;
            wait_cnt = 0;
            do begin
                @(negedge clk);
                wait_cnt++;
                if (wait_cnt > TIMEOUT) begin
                    report_timeout($sformatf("pushing read %0d", i));
                end
            end while (!req_ready);
            @(posedge clk);
            pushed++;
        end
        req_valid <= 1'b0;
    endtask

    task automatic collect_responses();
        int                wait_cnt;
        int                last_count;
        int                stall_len;
        logic [DATA_W-1:0] exp_data;
        last_count = 0;
        for (int i = 0; i < N_ENTRIES; i++) begin
            exp_data = DATA_W'(stim[i].addr) ^ MEM_KEY;
            if (stim[i].stall) begin
                rsp_ready <= 1'b0;
            end
            wait_cnt = 0;
            do begin
                @(negedge clk);
                wait_cnt++;
                if (wait_cnt > TIMEOUT) begin
                    report_timeout($sformatf("waiting for the response to read %0d", i));
                end
            end while (!rsp_valid);
            // A bus request since the previous response marks a miss
            check_miss(bit'(bus_count != last_count), stim[i].miss,
                       $sformatf("read %0d at %h", i, stim[i].addr));
            last_count = bus_count;
            if (stim[i].miss) begin
                check_bus_addr(bus_last_addr, stim[i].addr & ~ADDR_W'(BLOCK_W / 8 - 1),
                               $sformatf("bus address of read %0d", i));
            end
            check_word(rsp_data, exp_data, $sformatf("data of read %0d", i));
            if (stim[i].stall) begin
                stall_len = STALL_MIN + int'($urandom % 4);
                repeat (stall_len) begin
                    @(negedge clk);
                    if (!rsp_valid) begin
                        report_error($sformatf("response %0d dropped while stalled", i));
                    end
                    check_word(rsp_data, exp_data, $sformatf("held data of read %0d", i));
                end
                if (i + FIFO_DEPTH < N_ENTRIES) begin
                    if (req_ready || pushed - i - 1 != FIFO_DEPTH) begin
                        report_error($sformatf("queue holds %0d entries, ready=%0b, expected %0d",
                                               pushed - i - 1, req_ready, FIFO_DEPTH));
                    end
                end
                @(posedge clk);
                rsp_ready <= 1'b1;
            end
            @(posedge clk);
        end
    endtask

    initial begin
        rstn      = 1'b0;
        req_valid = 1'b0;
        req_addr  = '0;
        rsp_ready = 1'b1;
        void'($urandom(32'h7a2a7217));
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        fork
            drive_requests();
            collect_responses();
        join
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: test/bus_mem_model.sv
`timescale 1ns/1ps

module bus_mem_model
    import l1_cache_pkg::*;
#(
    parameter int                ADDR_W  = l1_cache_pkg::ADDR_W,
    parameter int                DATA_W  = l1_cache_pkg::DATA_W,
    parameter int                BLOCK_W = l1_cache_pkg::BLOCK_W,
    parameter logic [DATA_W-1:0] MEM_KEY = '0
) (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               req_valid_i,
    input  logic [ADDR_W-1:0]  req_addr_i,
    output logic               req_ready_o,
    output logic               rsp_valid_o,
    output logic [BLOCK_W-1:0] rsp_block_o,
    input  logic               rsp_ready_i,
    output logic [ADDR_W-1:0]  last_addr_o,
    output int                 req_count_o
);

    logic               req_ready_q = 1'b0;
    logic               rsp_valid_q = 1'b0;
    logic [BLOCK_W-1:0] rsp_block_q = '0;
    logic [ADDR_W-1:0]  last_addr_q = '0;
    int                 count_q     = 0;
    logic               busy_q      = 1'b0;
    int                 delay_q     = 0;

    // Word at byte address A is A xor MEM_KEY
    function automatic logic [BLOCK_W-1:0] read_block(input logic [ADDR_W-1:0] base);
        logic [BLOCK_W-1:0] blk;
        for (int i = 0; i < BLOCK_W / DATA_W; i++) begin
            blk[i*DATA_W +: DATA_W] = DATA_W'(base + ADDR_W'(i * DATA_W / 8)) ^ MEM_KEY;
        end
        return blk;
    endfunction

    assign req_ready_o = req_ready_q;
    assign rsp_valid_o = rsp_valid_q;
    assign rsp_block_o = rsp_block_q;
    assign last_addr_o = last_addr_q;
    assign req_count_o = count_q;

    always @(posedge clk_i) begin
        if (!rstn_i) begin
            req_ready_q <= 1'b0;
            rsp_valid_q <= 1'b0;
            count_q     <= 0;
            busy_q      <= 1'b0;
        end else if (!busy_q) begin
            if (req_valid_i && req_ready_q) begin
                busy_q      <= 1'b1;
                req_ready_q <= 1'b0;
                last_addr_q <= req_addr_i;
                count_q     <= count_q + 1;
                delay_q     <= $urandom % 6;
            end else begin
                // Ready drops now and then to hold the request
                req_ready_q <= ($urandom % 4) != 0;
            end
        end else if (!rsp_valid_q) begin
            if (delay_q == 0) begin
                rsp_valid_q <= 1'b1;
                rsp_block_q <= read_block(last_addr_q);
            end else begin
                delay_q <= delay_q - 1;
            end
        end else if (rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
            busy_q      <= 1'b0;
        end
    end

endmodule

// File: design/l1_cache_top.sv
`timescale 1ns/1ps

module l1_cache_top #(
    parameter int ADDR_W     = l1_cache_pkg::ADDR_W,
    parameter int DATA_W     = l1_cache_pkg::DATA_W,
    parameter int BLOCK_W    = l1_cache_pkg::BLOCK_W,
    parameter int WAYS       = l1_cache_pkg::WAYS,
    parameter int SETS       = l1_cache_pkg::SETS,
    parameter int FIFO_DEPTH = l1_cache_pkg::FIFO_DEPTH
) (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               req_valid_i,
    input  logic [ADDR_W-1:0]  req_addr_i,
    output logic               req_ready_o,
    output logic               rsp_valid_o,
    output logic [DATA_W-1:0]  rsp_data_o,
    input  logic               rsp_ready_i,
    output logic               bus_req_valid_o,
    output logic [ADDR_W-1:0]  bus_req_addr_o,
    input  logic               bus_req_ready_i,
    input  logic               bus_rsp_valid_i,
    input  logic [BLOCK_W-1:0] bus_rsp_block_i,
    output logic               bus_rsp_ready_o
);

    localparam int INDEX_W = $clog2(SETS);
    localparam int TAG_W   = ADDR_W - INDEX_W - $clog2(BLOCK_W / 8);

    logic                    q_valid;
    logic [ADDR_W-1:0]       q_addr;
    logic                    q_ready;
    logic                    ram_rd_en;
    logic [INDEX_W-1:0]      ram_index;
    logic [WAYS-1:0]         ram_wr_way;
    logic [TAG_W-1:0]        ram_wr_tag;
    logic [BLOCK_W-1:0]      ram_wr_block;
    logic [WAYS*TAG_W-1:0]   ram_tags;
    logic [WAYS*BLOCK_W-1:0] ram_blocks;

    l1_req_fifo #(
        .ADDR_W     (ADDR_W),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_l1_req_fifo (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .push_valid_i (req_valid_i),
        .push_addr_i  (req_addr_i),
        .push_ready_o (req_ready_o),
        .pop_valid_o  (q_valid),
        .pop_addr_o   (q_addr),
        .pop_ready_i  (q_ready)
    );

    l1_ctrl #(
        .ADDR_W  (ADDR_W),
        .DATA_W  (DATA_W),
        .BLOCK_W (BLOCK_W),
        .WAYS    (WAYS),
        .SETS    (SETS)
    ) u_l1_ctrl (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .q_valid_i       (q_valid),
        .q_addr_i        (q_addr),
        .q_ready_o       (q_ready),
        .ram_rd_en_o     (ram_rd_en),
        .ram_index_o     (ram_index),
        .ram_wr_way_o    (ram_wr_way),
        .ram_wr_tag_o    (ram_wr_tag),
        .ram_wr_block_o  (ram_wr_block),
        .ram_tags_i      (ram_tags),
        .ram_blocks_i    (ram_blocks),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_data_o      (rsp_data_o),
        .rsp_ready_i     (rsp_ready_i),
        .bus_req_valid_o (bus_req_valid_o),
        .bus_req_addr_o  (bus_req_addr_o),
        .bus_req_ready_i (bus_req_ready_i),
        .bus_rsp_valid_i (bus_rsp_valid_i),
        .bus_rsp_block_i (bus_rsp_block_i),
        .bus_rsp_ready_o (bus_rsp_ready_o)
    );

    l1_tag_data_ram #(
        .WAYS    (WAYS),
        .SETS    (SETS),
        .TAG_W   (TAG_W),
        .BLOCK_W (BLOCK_W)
    ) u_l1_tag_data_ram (
        .clk_i       (clk_i),
        .rd_en_i     (ram_rd_en),
        .index_i     (ram_index),
        .wr_way_i    (ram_wr_way),
        .wr_tag_i    (ram_wr_tag),
        .wr_block_i  (ram_wr_block),
        .rd_tags_o   (ram_tags),
        .rd_blocks_o (ram_blocks)
    );

endmodule

// File: design/l1_ctrl.sv
`timescale 1ns/1ps

module l1_ctrl
    import l1_cache_pkg::*;
#(
    parameter int ADDR_W    = l1_cache_pkg::ADDR_W,
    parameter int DATA_W    = l1_cache_pkg::DATA_W,
    parameter int BLOCK_W   = l1_cache_pkg::BLOCK_W,
    parameter int WAYS      = l1_cache_pkg::WAYS,
    parameter int SETS      = l1_cache_pkg::SETS,
    localparam int OFFSET_W = $clog2(BLOCK_W / 8),
    localparam int INDEX_W  = $clog2(SETS),
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W
) (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic                    q_valid_i,
    input  logic [ADDR_W-1:0]       q_addr_i,
    output logic                    q_ready_o,
    output logic                    ram_rd_en_o,
    output logic [INDEX_W-1:0]      ram_index_o,
    output logic [WAYS-1:0]         ram_wr_way_o,
    output logic [TAG_W-1:0]        ram_wr_tag_o,
    output logic [BLOCK_W-1:0]      ram_wr_block_o,
    input  logic [WAYS*TAG_W-1:0]   ram_tags_i,
    input  logic [WAYS*BLOCK_W-1:0] ram_blocks_i,
    output logic                    rsp_valid_o,
    output logic [DATA_W-1:0]       rsp_data_o,
    input  logic                    rsp_ready_i,
    output logic                    bus_req_valid_o,
    output logic [ADDR_W-1:0]       bus_req_addr_o,
    input  logic                    bus_req_ready_i,
    input  logic                    bus_rsp_valid_i,
    input  logic [BLOCK_W-1:0]      bus_rsp_block_i,
    output logic                    bus_rsp_ready_o
);

    localparam int WAY_W  = (WAYS > 1) ? $clog2(WAYS) : 1;
    localparam int BYTE_W = $clog2(DATA_W / 8);

    ctrl_state_e        state_q;
    logic [ADDR_W-1:0]  addr_q;
    logic [WAY_W-1:0]   victim_q;
    logic [DATA_W-1:0]  rsp_data_q;
    logic [WAYS-1:0]    valid_q [SETS];
    logic [WAY_W-1:0]   rr_q    [SETS];

    logic [INDEX_W-1:0] lk_index;
    logic [TAG_W-1:0]   lk_tag;
    logic               q_fire;
    logic               refill;
    logic               hit;
    logic [BLOCK_W-1:0] hit_block;
    logic               all_valid;
    logic [WAY_W-1:0]   victim;

    // Word select uses the bits between the byte offset and the block offset
    function automatic logic [DATA_W-1:0] pick_word(input logic [BLOCK_W-1:0] blk,
                                                    input logic [ADDR_W-1:0]  addr);
        return blk[addr[OFFSET_W-1:BYTE_W] * DATA_W +: DATA_W];
    endfunction

    function automatic logic [WAY_W-1:0] next_way(input logic [WAY_W-1:0] way);
        return (way == WAY_W'(WAYS - 1)) ? '0 : way + 1'b1;
    endfunction

    assign lk_index = addr_q[OFFSET_W +: INDEX_W];
    assign lk_tag   = addr_q[ADDR_W-1 -: TAG_W];
    assign q_fire   = (state_q == CTRL_IDLE) && q_valid_i;
    assign refill   = (state_q == CTRL_BUS_WAIT) && bus_rsp_valid_i;

    assign q_ready_o   = (state_q == CTRL_IDLE);
    assign ram_rd_en_o = q_fire;
    assign ram_index_o = (state_q == CTRL_IDLE) ? q_addr_i[OFFSET_W +: INDEX_W] : lk_index;

    // Refill writes the victim way straight from the bus
    assign ram_wr_way_o   = refill ? (WAYS'(1) << victim_q) : '0;
    assign ram_wr_tag_o   = lk_tag;
    assign ram_wr_block_o = bus_rsp_block_i;

    assign rsp_valid_o     = (state_q == CTRL_RESP);
    assign rsp_data_o      = rsp_data_q;
    assign bus_req_valid_o = (state_q == CTRL_BUS_REQ);
    assign bus_req_addr_o  = {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign bus_rsp_ready_o = (state_q == CTRL_BUS_WAIT);

    // Tag compare against the ways read in the previous cycle
    always_comb begin
        hit       = 1'b0;
        hit_block = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (valid_q[lk_index][w] && ram_tags_i[w*TAG_W +: TAG_W] == lk_tag) begin
                hit       = 1'b1;
                hit_block = ram_blocks_i[w*BLOCK_W +: BLOCK_W];
            end
        end
    end

    // Lowest invalid way first, else round robin
    always_comb begin
        all_valid = &valid_q[lk_index];
        victim    = rr_q[lk_index];
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!valid_q[lk_index][w]) begin
                victim = WAY_W'(w);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= CTRL_IDLE;
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
                rr_q[s]    <= '0;
            end
        end else begin
            case (state_q)
                CTRL_IDLE: begin
                    if (q_valid_i) begin
                        state_q <= CTRL_LOOKUP;
                    end
                end
                CTRL_LOOKUP: begin
                    if (hit) begin
                        state_q <= CTRL_RESP;
                    end else begin
                        state_q <= CTRL_BUS_REQ;
                        if (all_valid) begin
                            rr_q[lk_index] <= next_way(rr_q[lk_index]);
                        end
                    end
                end
                CTRL_BUS_REQ: begin
                    if (bus_req_ready_i) begin
                        state_q <= CTRL_BUS_WAIT;
                    end
                end
                CTRL_BUS_WAIT: begin
                    if (bus_rsp_valid_i) begin
                        valid_q[lk_index][victim_q] <= 1'b1;
                        state_q                     <= CTRL_RESP;
                    end
                end
                CTRL_RESP: begin
                    if (rsp_ready_i) begin
                        state_q <= CTRL_IDLE;
                    end
                end
                default: begin
                    state_q <= CTRL_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (q_fire) begin
            addr_q <= q_addr_i;
        end
        if (state_q == CTRL_LOOKUP) begin
            victim_q   <= victim;
            rsp_data_q <= pick_word(hit_block, addr_q);
        end
        if (refill) begin
            rsp_data_q <= pick_word(bus_rsp_block_i, addr_q);
        end
    end

    a_rsp_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_data_o));

    a_bus_req_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        bus_req_valid_o && !bus_req_ready_i |=> bus_req_valid_o && $stable(bus_req_addr_o));

endmodule

// File: design/l1_tag_data_ram.sv
`timescale 1ns/1ps

module l1_tag_data_ram #(
    parameter int WAYS    = l1_cache_pkg::WAYS,
    parameter int SETS    = l1_cache_pkg::SETS,
    parameter int TAG_W   = l1_cache_pkg::TAG_W,
    parameter int BLOCK_W = l1_cache_pkg::BLOCK_W
) (
    input  logic                      clk_i,
    input  logic                      rd_en_i,
    input  logic [$clog2(SETS)-1:0]   index_i,
    input  logic [WAYS-1:0]           wr_way_i,
    input  logic [TAG_W-1:0]          wr_tag_i,
    input  logic [BLOCK_W-1:0]        wr_block_i,
    output logic [WAYS*TAG_W-1:0]     rd_tags_o,
    output logic [WAYS*BLOCK_W-1:0]   rd_blocks_o
);

    // One BRAM pair per way, all ways read together
    for (genvar w = 0; w < WAYS; w++) begin : g_way
        logic [TAG_W-1:0]   tag_mem   [SETS];
        logic [BLOCK_W-1:0] block_mem [SETS];
        logic [TAG_W-1:0]   rd_tag_q;
        logic [BLOCK_W-1:0] rd_block_q;

        always_ff @(posedge clk_i) begin
            if (wr_way_i[w]) begin
                tag_mem[index_i]   <= wr_tag_i;
                block_mem[index_i] <= wr_block_i;
            end
        end

        // Output register holds its value between reads
        always_ff @(posedge clk_i) begin
            if (rd_en_i) begin
                rd_tag_q   <= tag_mem[index_i];
                rd_block_q <= block_mem[index_i];
            end
        end

        assign rd_tags_o[w*TAG_W +: TAG_W]       = rd_tag_q;
        assign rd_blocks_o[w*BLOCK_W +: BLOCK_W] = rd_block_q;
    end

    a_wr_way_onehot: assert property (@(posedge clk_i) $onehot0(wr_way_i));

endmodule

// File: design/l1_req_fifo.sv
`timescale 1ns/1ps

module l1_req_fifo #(
    parameter int ADDR_W     = 32,
    parameter int FIFO_DEPTH = 4
) (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              push_valid_i,
    input  logic [ADDR_W-1:0] push_addr_i,
    output logic              push_ready_o,
    output logic              pop_valid_o,
    output logic [ADDR_W-1:0] pop_addr_o,
    input  logic              pop_ready_i
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [ADDR_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              push;
    logic              pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push_ready_o = (count != CNT_W'(FIFO_DEPTH));
    assign pop_valid_o  = (count != '0);
    assign pop_addr_o   = mem[rd_ptr];
    assign push         = push_valid_i && push_ready_o;
    assign pop          = pop_valid_o && pop_ready_i;

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= push_addr_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rstn_i)
        count <= CNT_W'(FIFO_DEPTH));

endmodule

// File: design/l1_cache_pkg.sv
package l1_cache_pkg;

    // Default cache geometry
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int BLOCK_W    = 128;
    localparam int WAYS       = 2;
    localparam int SETS       = 16;
    localparam int FIFO_DEPTH = 4;

    // Address split into tag, index and byte offset
    localparam int OFFSET_W = $clog2(BLOCK_W / 8);
    localparam int INDEX_W  = $clog2(SETS);
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    // Controller FSM
    typedef enum logic [2:0] {
        CTRL_IDLE,
        CTRL_LOOKUP,
        CTRL_RESP,
        CTRL_BUS_REQ,
        CTRL_BUS_WAIT
    } ctrl_state_e;

endpackage
